/* source/fetchPkg.sv */
package fetchPkg;

	// mips cause register exception codes used by the fetch stage.
	localparam logic [4:0] excNone = 5'd0;
	localparam logic [4:0] excAdel = 5'd4;
	localparam logic [4:0] excIbe = 5'd6;

	// item between the pc generator and the fetch stage.
	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic exception;
		logic [4:0] excCode;
	} pfT;

	// item handed from fetch to decode.
	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic [31:0] instr;
		logic exception;
		logic [4:0] excCode;
	} idT;

	// wishbone classic read-only master request.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic [31:0] adr;
	} wbReqT;

	// wishbone classic slave response.
	typedef struct packed {
		logic ack;
		logic err;
		logic [31:0] dat;
	} wbRspT;

	// empty pipeline slots, loaded on reset and flush.
	localparam pfT pfEmpty = '{
		valid: 1'b0,
		pc: 32'h0,
		exception: 1'b0,
		excCode: excNone
	};

	localparam idT idEmpty = '{
		valid: 1'b0,
		pc: 32'h0,
		instr: 32'h0,
		exception: 1'b0,
		excCode: excNone
	};

endpackage

/* source/stageReg.sv */
`timescale 1ns/10ps

module stageReg #(
	parameter type payloadT = logic [31:0],
	parameter payloadT ResetValue = '0
) (
	input logic clk,
	input logic rstN,
	input logic wr,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	// flush has priority over a write, so a redirect always empties the slot.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			q <= ResetValue;
		end
		else if (flush) begin
			q <= ResetValue;
		end
		else if (wr) begin
			q <= d;
		end
	end

endmodule

/* source/pcGen.sv */
`timescale 1ns/10ps

module pcGen #(
	parameter logic [31:0] ResetPc = 32'hbfc00000
) (
	input logic clk,
	input logic rstN,
	input logic redirect,
	input logic [31:0] redirectPc,
	input logic pcAdvance,
	output fetchPkg::pfT pfNext
);

	logic [31:0] pc;
	logic misaligned;

	// a redirect overrides the sequential step.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= ResetPc;
		end
		else if (redirect) begin
			pc <= redirectPc;
		end
		else if (pcAdvance) begin
			pc <= pc + 32'd4;
		end
	end

	// instruction words must be word aligned.
	assign misaligned = |pc[1:0];

	always_comb begin
		pfNext = fetchPkg::pfEmpty;
		pfNext.valid = 1'b1;
		pfNext.pc = pc;
		if (misaligned) begin
			pfNext.exception = 1'b1;
			pfNext.excCode = fetchPkg::excAdel;
		end
	end

endmodule

/* source/busTimer.sv */
`timescale 1ns/10ps

module busTimer #(
	parameter int MaxWait = 16
) (
	input logic clk,
	input logic rstN,
	input logic timerRun,
	output logic timeout
);

	localparam int CntW = $clog2(MaxWait + 1);

	// strobe cycles already spent without an answer.
	logic [CntW-1:0] count;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end
		else if (!timerRun) begin
			count <= '0;
		end
		else begin
			count <= count + 1'b1;
		end
	end

	// fires in the last of MaxWait strobe cycles so cyc drops right after it.
	assign timeout = timerRun && (count == CntW'(MaxWait - 1));

	// the count reaches MaxWait only in the cycle after a timeout.
	countBound: assert property (@(posedge clk) disable iff (!rstN)
		count <= CntW'(MaxWait));

	// the master must abandon the cycle once the timer has fired.
	stopAfterTimeout: assert property (@(posedge clk) disable iff (!rstN)
		timeout |=> !timerRun);

endmodule

/* source/fetchCtrl.sv */
`timescale 1ns/10ps

module fetchCtrl (
	input logic clk,
	input logic rstN,
	input fetchPkg::pfT ifItem,
	input logic redirect,
	input logic idReady,
	input logic idValid,
	output fetchPkg::wbReqT wbReq,
	input fetchPkg::wbRspT wbRsp,
	input logic timeout,
	output logic timerRun,
	output logic pfWr,
	output logic pcAdvance,
	output fetchPkg::idT idNext,
	output logic idWr,
	output logic flush
);

	typedef enum logic [1:0] {
		idle,
		bus,
		drain
	} stateT;

	stateT state;
	stateT stateNext;

	logic idFree;
	logic answer;
	logic startBus;
	logic ifDone;
	logic idLoad;
	fetchPkg::idT idItemNew;

	// the decode slot is free if empty or handing its item over this cycle.
	assign idFree = !idValid || idReady;

	// any of these closes the open bus cycle.
	assign answer = wbRsp.ack || wbRsp.err || timeout;

	always_comb begin
		stateNext = state;
		startBus = 1'b0;
		ifDone = 1'b0;
		idLoad = 1'b0;
		idItemNew = fetchPkg::idEmpty;
		idItemNew.valid = 1'b1;
		idItemNew.pc = ifItem.pc;
		case (state)
			idle: begin
				if (ifItem.valid && !redirect && idFree) begin
					if (ifItem.exception) begin
						// bad address, goes to decode without touching the bus.
						idLoad = 1'b1;
						ifDone = 1'b1;
						idItemNew.exception = 1'b1;
						idItemNew.excCode = ifItem.excCode;
					end
					else begin
						startBus = 1'b1;
						stateNext = bus;
					end
				end
			end
			bus: begin
				if (redirect) begin
					stateNext = answer ? idle : drain;
				end
				else if (answer) begin
					stateNext = idle;
					idLoad = 1'b1;
					ifDone = 1'b1;
					if (wbRsp.ack) begin
						idItemNew.instr = wbRsp.dat;
					end
					else begin
						idItemNew.exception = 1'b1;
						idItemNew.excCode = fetchPkg::excIbe;
					end
				end
			end
			drain: begin
				// the answer belongs to a flushed item and is dropped.
				if (answer) begin
					stateNext = idle;
				end
			end
			default: begin
				stateNext = idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			wbReq <= '0;
		end
		else begin
			state <= stateNext;
			if (startBus) begin
				wbReq.cyc <= 1'b1;
				wbReq.stb <= 1'b1;
				wbReq.adr <= ifItem.pc;
			end
			else if (state != idle && answer) begin
				wbReq.cyc <= 1'b0;
				wbReq.stb <= 1'b0;
			end
		end
	end

	assign timerRun = wbReq.stb;

	// the fetch slot refills when empty or when its item has been used.
	assign pfWr = !ifItem.valid || ifDone;
	assign pcAdvance = pfWr && !redirect;

	// the decode slot clears after a transfer unless a new item arrives.
	assign idWr = idLoad || (idValid && idReady);
	assign idNext = idLoad ? idItemNew : fetchPkg::idEmpty;

	assign flush = redirect;

	stbHasCyc: assert property (@(posedge clk) disable iff (!rstN)
		wbReq.stb |-> wbReq.cyc);

	// a waiting strobe keeps its address until ack, err or timeout.
	adrStable: assert property (@(posedge clk) disable iff (!rstN)
		wbReq.stb && !answer |=> wbReq.stb && $stable(wbReq.adr));

endmodule

/* source/fetchUnit.sv */
`timescale 1ns/10ps

module fetchUnit #(
	parameter logic [31:0] ResetPc = 32'hbfc00000,
	parameter int MaxWait = 16
) (
	input logic clk,
	input logic rstN,
	output fetchPkg::wbReqT wbReq,
	input fetchPkg::wbRspT wbRsp,
	input logic redirect,
	input logic [31:0] redirectPc,
	output fetchPkg::idT idItem,
	input logic idReady
);

	fetchPkg::pfT pfNext;
	fetchPkg::pfT ifItem;
	fetchPkg::idT idNext;
	logic pfWr;
	logic idWr;
	logic flush;
	logic pcAdvance;
	logic timerRun;
	logic timeout;

	pcGen #(
		.ResetPc(ResetPc)
	) pcGen_inst (
		.clk(clk),
		.rstN(rstN),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.pcAdvance(pcAdvance),
		.pfNext(pfNext)
	);

	// prefetch to fetch.
	stageReg #(
		.payloadT(fetchPkg::pfT),
		.ResetValue(fetchPkg::pfEmpty)
	) pfStage (
		.clk(clk),
		.rstN(rstN),
		.wr(pfWr),
		.flush(flush),
		.d(pfNext),
		.q(ifItem)
	);

	fetchCtrl fetchCtrl_inst (
		.clk(clk),
		.rstN(rstN),
		.ifItem(ifItem),
		.redirect(redirect),
		.idReady(idReady),
		.idValid(idItem.valid),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.timeout(timeout),
		.timerRun(timerRun),
		.pfWr(pfWr),
		.pcAdvance(pcAdvance),
		.idNext(idNext),
		.idWr(idWr),
		.flush(flush)
	);

	busTimer #(
		.MaxWait(MaxWait)
	) busTimer_inst (
		.clk(clk),
		.rstN(rstN),
		.timerRun(timerRun),
		.timeout(timeout)
	);

	// fetch to decode.
	stageReg #(
		.payloadT(fetchPkg::idT),
		.ResetValue(fetchPkg::idEmpty)
	) idStage (
		.clk(clk),
		.rstN(rstN),
		.wr(idWr),
		.flush(flush),
		.d(idNext),
		.q(idItem)
	);

endmodule

/* tb/tbUtil.svh */
// one xorshift32 step.
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// instruction memory contents, every address bit changes the word.
function automatic logic [31:0] memWord(input logic [31:0] adr);
	return (adr * 32'h9e3779b1) ^ {adr[15:0], adr[31:16]};
endfunction

/* tb/instrMem.sv */
`timescale 1ns/10ps

module instrMem (
	input logic clk,
	input logic rstN,
	input fetchPkg::wbReqT wbReq,
	output fetchPkg::wbRspT wbRsp,
	input logic [31:0] rnd
);

	`include "tbUtil.svh"

	logic busy;
	logic hang;
	logic fail;
	logic [2:0] waitLeft;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbRsp <= '0;
			busy <= 1'b0;
			hang <= 1'b0;
			fail <= 1'b0;
			waitLeft <= 3'd0;
		end
		else begin
			wbRsp.ack <= 1'b0;
			wbRsp.err <= 1'b0;
			if (!(wbReq.cyc && wbReq.stb) || wbRsp.ack || wbRsp.err) begin
				busy <= 1'b0;
			end
			else if (!busy) begin
				// a new strobe picks its wait states and how it ends.
				busy <= 1'b1;
				waitLeft <= rnd[2:0] % 3'd6;
				hang <= rnd[12:3] < 10'd10;
				fail <= rnd[22:13] < 10'd20;
			end
			else if (!hang && waitLeft != 3'd0) begin
				waitLeft <= waitLeft - 3'd1;
			end
			else if (!hang) begin
				wbRsp.ack <= !fail;
				wbRsp.err <= fail;
				wbRsp.dat <= fail ? rnd : memWord(wbReq.adr);
			end
		end
	end

endmodule

/* tb/fetchUnitTb.sv */
`timescale 1ns/10ps

module fetchUnitTb;

	`include "tbUtil.svh"

	localparam logic [31:0] ResetPc = 32'hbfc00000;
	localparam int MaxWait = 16;
	localparam int Transfers = 3000;
	localparam int Period = 40;
	localparam int DriveDelay = 2;

	logic clk;
	logic rstN;
	fetchPkg::wbReqT wbReq;
	fetchPkg::wbRspT wbRsp;
	logic redirect;
	logic [31:0] redirectPc;
	fetchPkg::idT idItem;
	fetchPkg::idT itemPrev;
	logic idReady;
	logic [31:0] memRnd;
	logic [31:0] rngState;
	logic [31:0] expPc;
	logic [31:0] lastAdr;
	logic [31:0] expInstr;
	logic [5:0] expExc;
	logic started;
	logic answered;
	logic lastFail;
	logic holdPrev;
	logic flushPrev;
	int resetEdges;
	int stbCycles;
	int transfers;

	fetchUnit #(
		.ResetPc(ResetPc),
		.MaxWait(MaxWait)
	) fetchUnit_inst (
		.clk(clk),
		.rstN(rstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.idItem(idItem),
		.idReady(idReady)
	);

	instrMem memModel (
		.clk(clk),
		.rstN(rstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.rnd(memRnd)
	);

	always #(Period / 2) clk = ~clk;

	task automatic stopWithError(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(input string name, input logic [71:0] got,
		input logic [71:0] want);
		stopWithError($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, want));
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		redirect = 1'b0;
		redirectPc = 32'h0;
		idReady = 1'b0;
		memRnd = 32'h0;
		rngState = 32'h3eb4e9f3;
		expPc = ResetPc;
		lastAdr = 32'h0;
		started = 1'b0;
		answered = 1'b0;
		lastFail = 1'b0;
		holdPrev = 1'b0;
		flushPrev = 1'b0;
		itemPrev = fetchPkg::idEmpty;
		resetEdges = 0;
		stbCycles = 0;
		transfers = 0;
		repeat (5) @(posedge clk);
		#DriveDelay;
		rstN = 1'b1;
		wait (transfers == Transfers);
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		#((Transfers * (MaxWait + 8) + 10) * Period);
		stopWithError("watchdog expired before all transfers were seen");
	end

	// no redirect before the first bus cycle, so its address is ResetPc.
	always @(posedge clk) begin
		if (rstN) begin
			#DriveDelay;
			rngState = xorshift(rngState);
			redirect = started && rngState[9:0] < 10'd26;
			idReady = rngState[11:10] != 2'b00;
			rngState = xorshift(rngState);
			redirectPc = {rngState[31:2],
				(rngState[5:4] == 2'b00) ? (rngState[1:0] | 2'b01) : 2'b00};
			rngState = xorshift(rngState);
			memRnd = rngState;
		end
	end

	task automatic checkBus();
		if (wbReq.stb) begin
			assert (wbReq.cyc) else stopWithError("stb is high while cyc is low");
			assert (wbReq.adr[1:0] == 2'b00)
				else stopWithError("a misaligned address reached the bus");
			if (stbCycles == 0) begin
				if (!started) begin
					assert (wbReq.adr == ResetPc)
						else reportMismatch("wbReq.adr", 72'(wbReq.adr), 72'(ResetPc));
					started = 1'b1;
				end
				lastAdr = wbReq.adr;
			end
			stbCycles++;
			assert (stbCycles <= MaxWait)
				else stopWithError("a strobe outlived the bus timeout");
			if (wbRsp.ack || wbRsp.err) begin
				answered = 1'b1;
				lastFail = wbRsp.err;
			end
		end
		else begin
			assert (!wbReq.cyc) else stopWithError("cyc is high without a strobe");
			// no answer means the timer closed the cycle.
			if (stbCycles != 0 && !answered) begin
				assert (stbCycles == MaxWait)
					else reportMismatch("wbReq.stb cycles", 72'(stbCycles), 72'(MaxWait));
				lastFail = 1'b1;
			end
			stbCycles = 0;
			answered = 1'b0;
		end
	endtask

	task automatic checkDecode();
		if (flushPrev) begin
			assert (!idItem.valid) else stopWithError("a decode item survived a redirect");
		end
		if (holdPrev) begin
			assert (idItem == itemPrev) else reportMismatch("idItem", 72'(idItem), 72'(itemPrev));
		end
		holdPrev = idItem.valid && !idReady && !redirect;
		flushPrev = redirect;
		itemPrev = idItem;
		if (redirect) begin
			expPc = redirectPc;
		end
		else if (idItem.valid && idReady) begin
			assert (idItem.pc == expPc)
				else reportMismatch("idItem.pc", 72'(idItem.pc), 72'(expPc));
			if (expPc[1:0] != 2'b00) begin
				expExc = {1'b1, fetchPkg::excAdel};
				expInstr = 32'h0;
			end
			else begin
				assert (lastAdr == expPc)
					else reportMismatch("wbReq.adr", 72'(lastAdr), 72'(expPc));
				expExc = lastFail ? {1'b1, fetchPkg::excIbe} : 6'h0;
				expInstr = lastFail ? 32'h0 : memWord(expPc);
			end
			assert ({idItem.exception, idItem.excCode} == expExc)
				else reportMismatch("idItem.excCode", 72'({idItem.exception, idItem.excCode}),
					72'(expExc));
			assert (idItem.instr == expInstr)
				else reportMismatch("idItem.instr", 72'(idItem.instr), 72'(expInstr));
			expPc = expPc + 32'd4;
			transfers++;
		end
	endtask

	always @(posedge clk) begin
		if (!rstN || resetEdges != 0) begin
			// the first edge is where the asynchronous reset takes hold.
			if (resetEdges != 0) begin
				assert (!wbReq.cyc && !wbReq.stb && !idItem.valid)
					else stopWithError("bus or decode output active around reset");
			end
			resetEdges = rstN ? 0 : resetEdges + 1;
		end
		if (rstN) begin
			checkBus();
			checkDecode();
		end
	end

endmodule

/* fetchUnit.f */
+incdir+tb
source/fetchPkg.sv
source/stageReg.sv
source/pcGen.sv
source/busTimer.sv
source/fetchCtrl.sv
source/fetchUnit.sv
tb/instrMem.sv
tb/fetchUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= fetchUnitTb
FILELIST ?= fetchUnit.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIM ?= $(BUILD_DIR)/V$(TOP)

SOURCES := $(wildcard source/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)
